//--- exec_pkg.sv
`default_nettype none

package exec_pkg;

	// instruction class from decode.
	typedef enum logic [4:0] {
		OP_TYPE_ARITH  = 5'd0,
		OP_TYPE_BRANCH = 5'd1,  // reserved, not executed here.
		OP_TYPE_LDST   = 5'd2   // reserved, not executed here.
	} op_type_e;

	// arithmetic ops.
	typedef enum logic [5:0] {
		OP_ADD = 6'd0,
		OP_SUB = 6'd1,
		OP_AND = 6'd2,
		OP_OR  = 6'd3,
		OP_CLR = 6'd4,  // op_a with op_b bits cleared.
		OP_EQ  = 6'd5,
		OP_LT  = 6'd6,
		OP_LTU = 6'd7,
		OP_XOR = 6'd8,
		OP_OPA = 6'd9,
		OP_OPB = 6'd10
	} alu_op_e;

	// request handed over by decode.
	typedef struct packed {
		logic          instr_c;  // compressed encoding.
		op_type_e      op_type;
		alu_op_e       op;
		logic [31:0]   op_a;
		logic [31:0]   op_b;
		logic [5:0]    rd;
		logic [31:1]   pc;       // halfword address.
	} exec_req_t;

	// destination register write port.
	typedef struct packed {
		logic          wen;
		logic [5:0]    waddr;
		logic [31:0]   wdata;
	} rd_write_t;

	// pc after reset, byte address 0x80.
	localparam logic [31:1] RESET_PC = 31'h40;

	// pc increments in halfwords.
	localparam logic [31:1] PC_STEP_C  = 31'd1;
	localparam logic [31:1] PC_STEP_32 = 31'd2;

endpackage

`default_nettype wire

//--- exec_alu.sv
`default_nettype none

module exec_alu (
	input  wire exec_pkg::alu_op_e op,
	input  wire logic [31:0]       op_a,
	input  wire logic [31:0]       op_b,
	output logic [31:0]            result
);

	logic [31:0] sum;
	logic [31:0] diff;
	logic        lt_signed;
	logic        lt_unsigned;

	assign sum         = op_a + op_b;
	assign diff        = op_a - op_b;
	assign lt_signed   = $signed(op_a) < $signed(op_b);
	assign lt_unsigned = op_a < op_b;

	always_comb begin
		case (op)
			exec_pkg::OP_ADD: begin
				result = sum;
			end
			exec_pkg::OP_SUB: begin
				result = diff;
			end
			exec_pkg::OP_AND: begin
				result = op_a & op_b;
			end
			exec_pkg::OP_OR: begin
				result = op_a | op_b;
			end
			exec_pkg::OP_CLR: begin
				result = op_a & ~op_b;
			end
			exec_pkg::OP_EQ: begin
				result = {31'd0, (op_a == op_b)};
			end
			exec_pkg::OP_LT: begin
				result = {31'd0, lt_signed};
			end
			exec_pkg::OP_LTU: begin
				result = {31'd0, lt_unsigned};
			end
			exec_pkg::OP_XOR: begin
				result = op_a ^ op_b;
			end
			exec_pkg::OP_OPA: begin
				result = op_a;
			end
			exec_pkg::OP_OPB: begin
				result = op_b;
			end
			default: begin
				result = 32'd0;  // undefined op.
			end
		endcase
	end

endmodule

`default_nettype wire

//--- exec_unit.sv
`default_nettype none

module exec_unit (
	input  wire logic                clock,
	input  wire logic                reset,
	input  wire logic                decode_valid,
	input  wire exec_pkg::exec_req_t decode_req,
	output exec_pkg::rd_write_t      rd_write,
	output logic                     instr_complete,
	output exec_pkg::exec_req_t      complete_req,
	output logic [31:1]              pc,
	output logic                     pc_seq
);

	logic [31:0]         alu_result;
	exec_pkg::exec_req_t stage1_req;
	logic [31:1]         pc_step;
	logic [31:1]         pc_next;

	exec_alu alu_i (
		.op     (decode_req.op),
		.op_a   (decode_req.op_a),
		.op_b   (decode_req.op_b),
		.result (alu_result)
	);

	// stage one valid is the write enable itself.
	always_ff @(posedge clock) begin
		if (reset) begin
			rd_write.wen <= 1'b0;
		end else begin
			rd_write.wen <= decode_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (decode_valid) begin
			rd_write.waddr <= decode_req.rd;
			rd_write.wdata <= alu_result;
			stage1_req     <= decode_req;
		end
	end

	// step by halfwords.
	assign pc_step = stage1_req.instr_c ? exec_pkg::PC_STEP_C : exec_pkg::PC_STEP_32;
	assign pc_next = stage1_req.pc + pc_step;

	// stage two: completion and architectural pc.
	always_ff @(posedge clock) begin
		if (reset) begin
			instr_complete <= 1'b0;
			pc_seq         <= 1'b0;
			pc             <= exec_pkg::RESET_PC;
		end else begin
			instr_complete <= rd_write.wen;
			pc_seq         <= rd_write.wen && (stage1_req.pc == pc);
			if (rd_write.wen) begin
				pc <= pc_next;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rd_write.wen) begin
			complete_req <= stage1_req;
		end
	end

	// each write is followed by its completion one cycle later.
	write_then_complete: assert property (
		@(posedge clock) disable iff (reset)
		rd_write.wen |=> instr_complete
	) else $error("exec_unit: write without completion on the next cycle");

	// and no completion appears without a write before it.
	complete_after_write: assert property (
		@(posedge clock) disable iff (reset)
		instr_complete |-> $past(rd_write.wen)
	) else $error("exec_unit: completion without a preceding write");

endmodule

`default_nettype wire

//--- exec_arith_checker.sv
`default_nettype none

module exec_arith_checker (
	input  wire logic                clock,
	input  wire logic                reset,
	input  wire exec_pkg::rd_write_t rd_write,
	input  wire logic                instr_complete,
	input  wire exec_pkg::exec_req_t complete_req,
	output logic                     check_fail,
	output logic [15:0]              check_count
);

	logic [1:0]  wr_count;  // writes since last completion.
	logic [5:0]  wr_addr;
	logic [31:0] wr_data;
	logic [31:0] model_result;
	logic        op_known;
	logic        bad;

	// reference model, kept apart from exec_alu.
	always_comb begin
		op_known     = 1'b1;
		model_result = 32'd0;
		case (complete_req.op)
			exec_pkg::OP_ADD: model_result = complete_req.op_a + complete_req.op_b;
			exec_pkg::OP_SUB: model_result = complete_req.op_a - complete_req.op_b;
			exec_pkg::OP_AND: model_result = complete_req.op_a & complete_req.op_b;
			exec_pkg::OP_OR:  model_result = complete_req.op_a | complete_req.op_b;
			exec_pkg::OP_CLR: begin
				model_result = complete_req.op_a ^ (complete_req.op_a & complete_req.op_b);
			end
			exec_pkg::OP_EQ: begin
				model_result = (complete_req.op_a == complete_req.op_b) ? 32'd1 : 32'd0;
			end
			exec_pkg::OP_LT: begin
				model_result = ($signed(complete_req.op_a) < $signed(complete_req.op_b)) ?
					32'd1 : 32'd0;
			end
			exec_pkg::OP_LTU: begin
				model_result = (complete_req.op_a < complete_req.op_b) ? 32'd1 : 32'd0;
			end
			exec_pkg::OP_XOR: model_result = complete_req.op_a ^ complete_req.op_b;
			exec_pkg::OP_OPA: model_result = complete_req.op_a;
			exec_pkg::OP_OPB: model_result = complete_req.op_b;
			default: begin
				op_known = 1'b0;
			end
		endcase
		if (complete_req.op_type != exec_pkg::OP_TYPE_ARITH) begin
			op_known = 1'b0;  // only arith is executed.
		end
	end

	assign bad = instr_complete && ((wr_count != 2'd1) ||
		(wr_addr != complete_req.rd) ||
		!op_known ||
		(wr_data != model_result));

	// write bookkeeping, restarted at each completion.
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_count <= 2'd0;
		end else if (instr_complete) begin
			wr_count <= rd_write.wen ? 2'd1 : 2'd0;
		end else if (rd_write.wen && wr_count != 2'd3) begin
			wr_count <= wr_count + 2'd1;  // saturates.
		end
	end

	always_ff @(posedge clock) begin
		if (rd_write.wen) begin
			wr_addr <= rd_write.waddr;
			wr_data <= rd_write.wdata;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			check_fail  <= 1'b0;
			check_count <= 16'd0;
		end else begin
			check_fail <= check_fail | bad;  // sticky.
			if (instr_complete) begin
				check_count <= check_count + 16'd1;
			end
		end
	end

	completing_op_known: assert property (
		@(posedge clock) disable iff (reset)
		instr_complete |-> !$isunknown(complete_req.op)
	) else $error("exec_arith_checker: completion with unknown op bits");

	// only reset may clear a failure.
	fail_is_sticky: assert property (
		@(posedge clock)
		$fell(check_fail) |-> $past(reset)
	) else $error("exec_arith_checker: check_fail dropped without reset");

endmodule

`default_nettype wire

//--- exec_subsys.sv
`default_nettype none

module exec_subsys (
	input  wire logic                clock,
	input  wire logic                reset,
	input  wire logic                decode_valid,
	input  wire exec_pkg::exec_req_t decode_req,
	output wire exec_pkg::rd_write_t rd_write,
	output wire logic                instr_complete,
	output wire exec_pkg::exec_req_t complete_req,
	output wire logic [31:1]         pc,
	output wire logic                pc_seq,
	output wire logic                check_fail,
	output wire logic [15:0]         check_count
);

	// two-stage execute path.
	exec_unit unit_i (
		.clock          (clock),
		.reset          (reset),
		.decode_valid   (decode_valid),
		.decode_req     (decode_req),
		.rd_write       (rd_write),
		.instr_complete (instr_complete),
		.complete_req   (complete_req),
		.pc             (pc),
		.pc_seq         (pc_seq)
	);

	// watches writes and completions only.
	exec_arith_checker checker_i (
		.clock          (clock),
		.reset          (reset),
		.rd_write       (rd_write),
		.instr_complete (instr_complete),
		.complete_req   (complete_req),
		.check_fail     (check_fail),
		.check_count    (check_count)
	);

endmodule

`default_nettype wire

//--- tb_exec_subsys.sv
`default_nettype none

module tb_exec_subsys;

	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		exec_pkg::alu_op_e op;
		logic [31:0]       op_a;
		logic [31:0]       op_b;
		logic [5:0]        rd;
		logic              instr_c;
		logic [3:0]        gap;       // idle cycles after the strobe.
		logic [31:0]       expected;
	} stim_t;

	typedef struct packed {
		exec_pkg::exec_req_t req;
		logic [31:0]         expected;
		logic [31:0]         cycle;     // cycle the strobe was driven.
	} expect_t;

	logic                clock;
	logic                reset;
	logic                decode_valid;
	exec_pkg::exec_req_t decode_req;
	exec_pkg::rd_write_t rd_write;
	logic                instr_complete;
	exec_pkg::exec_req_t complete_req;
	logic [31:1]         pc;
	logic                pc_seq;
	logic                check_fail;
	logic [15:0]         check_count;

	stim_t       stim_q[$];
	expect_t     write_q[$];
	expect_t     complete_q[$];
	int          cycle = 0;
	int          issued = 0;
	int          writes_seen = 0;
	int          completions_seen = 0;
	int          errors = 0;
	integer      seed = 48;
	logic [31:1] model_pc = exec_pkg::RESET_PC;

	exec_subsys dut_i (
		.clock          (clock),
		.reset          (reset),
		.decode_valid   (decode_valid),
		.decode_req     (decode_req),
		.rd_write       (rd_write),
		.instr_complete (instr_complete),
		.complete_req   (complete_req),
		.pc             (pc),
		.pc_seq         (pc_seq),
		.check_fail     (check_fail),
		.check_count    (check_count)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#10 clock = ~clock;
		end
	end

	always @(posedge clock) begin
		cycle <= cycle + 1;
	end

	function automatic logic [31:0] rule_result(input exec_pkg::alu_op_e op,
		input logic [31:0] a, input logic [31:0] b);
		case (op)
			exec_pkg::OP_ADD: return a + b;
			exec_pkg::OP_SUB: return a - b;
			exec_pkg::OP_AND: return a & b;
			exec_pkg::OP_OR:  return a | b;
			exec_pkg::OP_CLR: return a & ~b;
			exec_pkg::OP_EQ:  return (a == b) ? 32'd1 : 32'd0;
			exec_pkg::OP_LT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			exec_pkg::OP_LTU: return (a < b) ? 32'd1 : 32'd0;
			exec_pkg::OP_XOR: return a ^ b;
			exec_pkg::OP_OPA: return a;
			exec_pkg::OP_OPB: return b;
			default:          return 32'd0;
		endcase
	endfunction

	task automatic add_entry(input exec_pkg::alu_op_e op, input logic [31:0] a,
		input logic [31:0] b, input logic [5:0] rd, input logic c, input logic [3:0] gap,
		input logic [31:0] expected);
		stim_t s;
		s.op       = op;
		s.op_a     = a;
		s.op_b     = b;
		s.rd       = rd;
		s.instr_c  = c;
		s.gap      = gap;
		s.expected = expected;
		stim_q.push_back(s);
	endtask

	task automatic wait_writes(input int target);
		int n;
		n = 0;
		while (writes_seen < target && n < 20) begin
			@(posedge clock);
			#2;
			n++;
		end
		if (writes_seen < target) begin
			errors++;
			$display("timeout: register write did not arrive within 20 cycles");
		end
	endtask

	task automatic wait_completions(input int target);
		int n;
		n = 0;
		while (completions_seen < target && n < 20) begin
			@(posedge clock);
			#2;
			n++;
		end
		if (completions_seen < target) begin
			errors++;
			$display("timeout: instruction did not complete within 20 cycles");
		end
	endtask

	task automatic apply_entry(input stim_t s, inout logic [31:1] next_pc, input logic jump);
		exec_pkg::exec_req_t req;
		expect_t             x;
		req         = '0;
		req.instr_c = s.instr_c;
		req.op_type = exec_pkg::OP_TYPE_ARITH;
		req.op      = s.op;
		req.op_a    = s.op_a;
		req.op_b    = s.op_b;
		req.rd      = s.rd;
		req.pc      = jump ? next_pc + 31'h100 : next_pc;  // breaks the sequence.
		next_pc     = req.pc + (s.instr_c ? 31'd1 : 31'd2);
		x.req       = req;
		x.expected  = s.expected;
		x.cycle     = cycle;
		write_q.push_back(x);
		complete_q.push_back(x);
		decode_req   = req;
		decode_valid = 1'b1;
		@(posedge clock);
		#2;
		decode_valid = 1'b0;
		issued++;
		if (s.gap != 0) begin
			wait_writes(issued);
			wait_completions(issued);
			repeat (s.gap) begin
				@(posedge clock);
				#2;
			end
		end
	endtask

	task automatic check_write();
		expect_t x;
		writes_seen++;
		if (write_q.size() == 0) begin
			errors++;
			$display("register write seen with no instruction pending");
		end else begin
			x = write_q.pop_front();
			if (cycle != x.cycle + 1) begin
				errors++;
				$display("register write for rd %0d arrived in the wrong cycle", x.req.rd);
			end
			if (rd_write.waddr !== x.req.rd) begin
				errors++;
				$display("CHECK FAILED rd_write.waddr: got %h expected %h",
					rd_write.waddr, x.req.rd);
			end
			if (rd_write.wdata !== x.expected) begin
				errors++;
				$display("CHECK FAILED rd_write.wdata: got %h expected %h",
					rd_write.wdata, x.expected);
			end
		end
	endtask

	task automatic check_complete();
		expect_t     x;
		logic [31:1] exp_pc;
		logic        exp_seq;
		completions_seen++;
		if (complete_q.size() == 0) begin
			errors++;
			$display("completion seen with no instruction pending");
		end else begin
			x       = complete_q.pop_front();
			exp_pc  = x.req.pc + (x.req.instr_c ? 31'd1 : 31'd2);
			exp_seq = (x.req.pc == model_pc);
			if (cycle != x.cycle + 2) begin
				errors++;
				$display("completion for rd %0d arrived in the wrong cycle", x.req.rd);
			end
			if (complete_req !== x.req) begin
				errors++;
				$display("CHECK FAILED complete_req: got %h expected %h",
					complete_req, x.req);
			end
			if (pc !== exp_pc) begin
				errors++;
				$display("CHECK FAILED pc: got %h expected %h", pc, exp_pc);
			end
			if (pc_seq !== exp_seq) begin
				errors++;
				$display("CHECK FAILED pc_seq: got %h expected %h", pc_seq, exp_seq);
			end
			model_pc = exp_pc;
		end
	endtask

	// outputs settle well before the falling edge.
	always @(negedge clock) begin
		if (!reset) begin
			if (rd_write.wen === 1'b1) begin
				check_write();
			end
			if (instr_complete === 1'b1) begin
				check_complete();
			end else if (pc_seq !== 1'b0) begin
				errors++;
				$display("CHECK FAILED pc_seq: got %h expected 0", pc_seq);
			end
		end
	end

	initial begin
		logic [31:1]       drive_pc;
		logic [5:0]        code;
		logic [31:0]       a;
		logic [31:0]       b;
		logic [31:0]       r;
		exec_pkg::alu_op_e op;
		reset        = 1'b1;
		decode_valid = 1'b0;
		decode_req   = '0;
		drive_pc     = exec_pkg::RESET_PC;

		add_entry(exec_pkg::OP_ADD, 32'h00000005, 32'h00000003, 6'd1, 1'b0, 4'd2, 32'h00000008);
		add_entry(exec_pkg::OP_ADD, 32'hffffffff, 32'h00000001, 6'd2, 1'b1, 4'd0, 32'h00000000);
		add_entry(exec_pkg::OP_ADD, 32'h7fffffff, 32'h00000001, 6'd3, 1'b0, 4'd0, 32'h80000000);
		add_entry(exec_pkg::OP_SUB, 32'h00000000, 32'h00000001, 6'd4, 1'b0, 4'd1, 32'hffffffff);
		add_entry(exec_pkg::OP_SUB, 32'h80000000, 32'h00000001, 6'd5, 1'b1, 4'd0, 32'h7fffffff);
		add_entry(exec_pkg::OP_AND, 32'hffffffff, 32'h80000000, 6'd6, 1'b0, 4'd0, 32'h80000000);
		add_entry(exec_pkg::OP_AND, 32'h7fffffff, 32'h80000000, 6'd7, 1'b0, 4'd3, 32'h00000000);
		add_entry(exec_pkg::OP_OR, 32'h80000000, 32'h7fffffff, 6'd8, 1'b1, 4'd0, 32'hffffffff);
		add_entry(exec_pkg::OP_OR, 32'h00000000, 32'h00000000, 6'd9, 1'b0, 4'd1, 32'h00000000);
		add_entry(exec_pkg::OP_CLR, 32'hffffffff, 32'h80000000, 6'd10, 1'b0, 4'd0, 32'h7fffffff);
		add_entry(exec_pkg::OP_CLR, 32'h12345678, 32'h0000ffff, 6'd11, 1'b1, 4'd2, 32'h12340000);
		add_entry(exec_pkg::OP_EQ, 32'h80000000, 32'h80000000, 6'd12, 1'b0, 4'd0, 32'h00000001);
		add_entry(exec_pkg::OP_EQ, 32'h7fffffff, 32'h80000000, 6'd13, 1'b0, 4'd0, 32'h00000000);
		add_entry(exec_pkg::OP_LT, 32'h80000000, 32'h7fffffff, 6'd14, 1'b0, 4'd1, 32'h00000001);
		add_entry(exec_pkg::OP_LT, 32'h7fffffff, 32'h80000000, 6'd15, 1'b1, 4'd0, 32'h00000000);
		add_entry(exec_pkg::OP_LT, 32'hffffffff, 32'h00000000, 6'd16, 1'b0, 4'd0, 32'h00000001);
		add_entry(exec_pkg::OP_LT, 32'h80000000, 32'h80000000, 6'd0, 1'b0, 4'd2, 32'h00000000);
		add_entry(exec_pkg::OP_LTU, 32'h80000000, 32'h7fffffff, 6'd17, 1'b0, 4'd0, 32'h00000000);
		add_entry(exec_pkg::OP_LTU, 32'h00000000, 32'hffffffff, 6'd18, 1'b1, 4'd0, 32'h00000001);
		add_entry(exec_pkg::OP_LTU, 32'hffffffff, 32'hffffffff, 6'd19, 1'b0, 4'd1, 32'h00000000);
		add_entry(exec_pkg::OP_XOR, 32'hffffffff, 32'h80000000, 6'd20, 1'b0, 4'd0, 32'h7fffffff);
		add_entry(exec_pkg::OP_XOR, 32'ha5a5a5a5, 32'h5a5a5a5a, 6'd21, 1'b1, 4'd0, 32'hffffffff);
		add_entry(exec_pkg::OP_OPA, 32'hdeadbeef, 32'h00000000, 6'd22, 1'b0, 4'd0, 32'hdeadbeef);
		add_entry(exec_pkg::OP_OPB, 32'hdeadbeef, 32'h7fffffff, 6'd63, 1'b0, 4'd2, 32'h7fffffff);

		// random operands, ops in turn.
		for (int i = 0; i < 16; i++) begin
			code = i % 11;
			op   = exec_pkg::alu_op_e'(code);
			a    = $random(seed);
			b    = $random(seed);
			r    = $random(seed);
			if (op == exec_pkg::OP_EQ) begin
				b = a;
			end
			add_entry(op, a, b, r[5:0], r[6], {2'b00, r[9:8]}, rule_result(op, a, b));
		end

		repeat (8) @(posedge clock);
		#2;
		reset = 1'b0;

		if (rd_write.wen !== 1'b0 || instr_complete !== 1'b0 || pc_seq !== 1'b0) begin
			errors++;
			$display("CHECK FAILED wen, instr_complete, pc_seq: got %h %h %h expected 0 0 0",
				rd_write.wen, instr_complete, pc_seq);
		end
		if (check_fail !== 1'b0) begin
			errors++;
			$display("CHECK FAILED check_fail: got %h expected 0", check_fail);
		end
		if (check_count !== 16'd0) begin
			errors++;
			$display("CHECK FAILED check_count: got %h expected 0000", check_count);
		end
		if (pc !== exec_pkg::RESET_PC) begin
			errors++;
			$display("CHECK FAILED pc: got %h expected %h", pc, exec_pkg::RESET_PC);
		end

		for (int i = 0; i < stim_q.size(); i++) begin
			apply_entry(stim_q[i], drive_pc, (i % 5) == 4);
		end
		wait_writes(issued);
		wait_completions(issued);
		@(posedge clock);
		#2;

		if (check_count !== 16'(issued)) begin
			errors++;
			$display("CHECK FAILED check_count: got %h expected %h", check_count, 16'(issued));
		end
		if (check_fail !== 1'b0) begin
			errors++;
			$display("CHECK FAILED check_fail: got %h expected 0", check_fail);
		end

		$display("instructions %0d, writes %0d, completions %0d, errors %0d",
			issued, writes_seen, completions_seen, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
exec_pkg.sv
exec_alu.sv
exec_unit.sv
exec_arith_checker.sv
exec_subsys.sv
tb_exec_subsys.sv

//--- Bender.yml
package:
  name: exec_subsys

sources:
  - exec_pkg.sv
  - exec_alu.sv
  - exec_unit.sv
  - exec_arith_checker.sv
  - exec_subsys.sv
  - target: test
    files:
      - tb_exec_subsys.sv
